// ==== host_link_stim.txt ====
# cmd kind(0 rd, 1 wr) addr data expected name | credit | ret type reg_id data | idle n
# quiet n name | drain name | stall n addr0 expected0 addr1 expected1 name
cmd 0 02000 0 4 credits_reset
cmd 1 01000 cafef00d05030102 0 store_word_lo
cmd 1 01000 0000800010040107 0 store_word_hi
drain store_pkt
cmd 0 02000 0 3 credits_after_store
cmd 1 01000 5555555505030102 0 load_word_lo
cmd 1 01000 000000002006002a 0 load_word_hi
drain load_pkt
cmd 0 02000 0 2 credits_after_load
cmd 1 01000 1111111105030102 0 fill_a_lo
cmd 1 01000 0000000001000101 0 fill_a_hi
cmd 1 01000 2222222205030102 0 fill_b_lo
cmd 1 01000 0000000002000102 0 fill_b_hi
drain fill_pkts
cmd 0 02000 0 0 credits_empty
cmd 1 01000 3333333305030102 0 blocked_lo
cmd 1 01000 0000000003000103 0 blocked_hi
quiet 20 no_credit_hold
cmd 0 02000 0 0 credits_still_empty
credit
drain blocked_pkt
cmd 0 02000 0 0 credits_after_pulse
credit
credit
cmd 0 02000 0 2 credits_returned
ret 00 2a deadbeef
idle 4
cmd 0 04000 0 1 entries_full
cmd 0 03000 0 00deadbeef2a0503 resp_lo
cmd 0 03000 0 0 resp_hi
cmd 0 04000 0 0 entries_empty
ret 01 11 12345678
idle 4
cmd 0 04000 0 1 ack_entries
cmd 1 03000 0 0112345678110503 ack_lo
cmd 0 03000 0 0 ack_hi
cmd 0 04000 0 0 ack_entries_empty
cmd 0 00010 0 0 unmapped_rd
cmd 1 05000 ffffffffffffffff 0 unmapped_wr
stall 6 02000 2 05000 0 back_pressure

// ==== list.f ====
host_link_pkg.sv
host_cmd_fifo.sv
host_req_sipo.sv
host_resp_piso.sv
host_link_regs.sv
host_net_port.sv
host_link_top.sv
tb_host_link.sv

// ==== Bender.yml ====
package:
  name: host_link

sources:
  - host_link_pkg.sv
  - host_cmd_fifo.sv
  - host_req_sipo.sv
  - host_resp_piso.sv
  - host_link_regs.sv
  - host_net_port.sv
  - host_link_top.sv
  - target: test
    files:
      - tb_host_link.sv

// ==== tb_host_link.sv ====
`timescale 1ns/1ps

module tb_host_link;
  import host_link_pkg::*;

  localparam int max_credits_c = 4;
  localparam int ret_els_c     = 4;
  localparam int timeout_c     = 200;
  localparam logic [7:0] my_x_c = 8'h03;
  localparam logic [7:0] my_y_c = 8'h05;

  logic      clk_i;
  logic      rst_n_i;
  host_msg_s host_cmd_i;
  logic      host_cmd_v_i;
  logic      host_cmd_ready_o;
  host_msg_s host_resp_o;
  logic      host_resp_v_o;
  logic      host_resp_yumi_i;
  net_pkt_s  net_pkt_o;
  logic      net_pkt_v_o;
  logic      net_credit_i;
  net_ret_s  net_ret_i;
  logic      net_ret_v_i;

  int err_count  = 0;
  int test_count = 0;
  int pkt_seen   = 0;
  bit abort      = 0;

  // expected network packets from the words the host wrote
  net_pkt_s         exp_pkt_q [$];
  logic [255:0]     exp_name_q [$];
  logic [63:0]      req_lo;
  bit               req_half = 0;

  host_link_top
  #(
    .max_credits_p  (max_credits_c),
    .ret_fifo_els_p (ret_els_c)
  ) host_link_top_i
  (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .host_cmd_i       (host_cmd_i),
    .host_cmd_v_i     (host_cmd_v_i),
    .host_cmd_ready_o (host_cmd_ready_o),
    .host_resp_o      (host_resp_o),
    .host_resp_v_o    (host_resp_v_o),
    .host_resp_yumi_i (host_resp_yumi_i),
    .net_pkt_o        (net_pkt_o),
    .net_pkt_v_o      (net_pkt_v_o),
    .net_credit_i     (net_credit_i),
    .net_ret_i        (net_ret_i),
    .net_ret_v_i      (net_ret_v_i),
    .my_x_i           (my_x_c),
    .my_y_i           (my_y_c)
  );

  initial
  begin
    clk_i = 1'b0;
  end

  always #2 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic step();
    @(posedge clk_i);
    #0.5;
  endtask

  // word address and byte offset as load payload
  function automatic net_pkt_s expect_pkt(input host_req_pkt_s req);
    net_pkt_s p;
    p.addr   = req.addr[31:2];
    p.op     = req.op;
    p.reg_id = req.reg_id;
    if (req.op == e_remote_store)
      p.payload = req.data;
    else
      p.payload = {30'b0, req.addr[1:0]};
    p.y_src = req.y_src;
    p.x_src = req.x_src;
    p.y_dst = req.y_dst;
    p.x_dst = req.x_dst;
    return p;
  endfunction

  task automatic end_test(input logic [255:0] name, input int errs0);
    test_count++;
    if (err_count == errs0)
      $display("%0s: ok", name);
    else
      $display("%0s: mismatch", name);
  endtask

  task automatic check_line_fields(input int got, input int want);
    if (got != want)
    begin
      $display("stimulus line has %0d fields where %0d were expected", got, want);
      err_count++;
      abort = 1;
    end
  endtask

  task automatic send_cmd(input logic kind, input logic [19:0] addr,
                          input logic [63:0] data, input logic [255:0] name);
    int waited;
    waited = 0;
    host_cmd_i.header.msg_type = host_msg_e'(kind);
    host_cmd_i.header.addr     = addr;
    host_cmd_i.data            = data;
    host_cmd_v_i               = 1'b1;
    while (host_cmd_ready_o !== 1'b1 && waited < timeout_c)
    begin
      step();
      waited++;
    end
    if (host_cmd_ready_o !== 1'b1)
    begin
      $display("%0s: the bridge never accepted the command", name);
      err_count++;
      abort = 1;
    end
    step();
    host_cmd_v_i = 1'b0;
  endtask

  task automatic wait_resp(input logic [255:0] name);
    int waited;
    waited = 0;
    while (host_resp_v_o !== 1'b1 && waited < timeout_c)
    begin
      step();
      waited++;
    end
    if (host_resp_v_o !== 1'b1)
    begin
      $display("%0s: no response arrived in %0d cycles", name, timeout_c);
      err_count++;
      abort = 1;
    end
  endtask

  task automatic take_resp(output host_msg_s resp, input logic [255:0] name);
    wait_resp(name);
    resp = host_resp_o;
    if (!abort)
    begin
      host_resp_yumi_i = 1'b1;
      step();
      host_resp_yumi_i = 1'b0;
    end
  endtask

  task automatic check_resp(input logic [255:0] name, input logic kind,
                            input logic [19:0] addr, input logic [63:0] exp,
                            input host_msg_s resp);
    host_msg_header_s hdr;
    hdr.msg_type = host_msg_e'(kind);
    hdr.addr     = addr;
    assert (resp.header === hdr)
    else
    begin
      $display("Error: %0s header expected %h actual %h", name, hdr, resp.header);
      err_count++;
    end
    assert (resp.data === exp)
    else
    begin
      $display("Error: %0s data expected %h actual %h", name, exp, resp.data);
      err_count++;
    end
  endtask

  // ----------------------------------------------------------------------
  // host commands and network events
  // ----------------------------------------------------------------------
  task automatic run_cmd(input logic kind, input logic [19:0] addr,
                         input logic [63:0] data, input logic [63:0] exp,
                         input logic [255:0] name);
    host_msg_s     resp;
    host_req_pkt_s req;
    int            errs0;
    errs0 = err_count;
    send_cmd(kind, addr, data, name);
    if (!abort)
      take_resp(resp, name);
    if (!abort)
    begin
      check_resp(name, kind, addr, exp, resp);
      // exactly one response per command
      assert (host_resp_v_o !== 1'b1)
      else
      begin
        $display("%0s: a second response appeared for one command", name);
        err_count++;
      end
      if (addr == reg_req_fifo_c)
      begin
        if (!req_half)
        begin
          req_lo   = data;
          req_half = 1;
        end
        else
        begin
          req = host_req_pkt_s'({data, req_lo});
          exp_pkt_q.push_back(expect_pkt(req));
          exp_name_q.push_back(name);
          req_half = 0;
        end
      end
    end
    end_test(name, errs0);
  endtask

  task automatic drain_pkts(input logic [255:0] name);
    int waited;
    int errs0;
    errs0  = err_count;
    waited = 0;
    while (exp_pkt_q.size() != 0 && waited < timeout_c)
    begin
      step();
      waited++;
    end
    if (exp_pkt_q.size() != 0)
    begin
      $display("%0s: expected network packet never left the bridge", name);
      err_count++;
      abort = 1;
    end
    end_test(name, errs0);
  endtask

  task automatic quiet_window(input int n, input logic [255:0] name);
    int start;
    int errs0;
    errs0 = err_count;
    start = pkt_seen;
    repeat (n) step();
    assert (pkt_seen == start)
    else
    begin
      $display("Error: %0s packets expected %0d actual %0d", name, start, pkt_seen);
      err_count++;
    end
    end_test(name, errs0);
  endtask

  task automatic stall_test(input int n, input logic [19:0] addr0, input logic [63:0] exp0,
                            input logic [19:0] addr1, input logic [63:0] exp1,
                            input logic [255:0] name);
    host_msg_s held;
    host_msg_s resp;
    int        errs0;
    errs0 = err_count;
    send_cmd(1'b0, addr0, 64'h0, name);
    if (!abort)
      send_cmd(1'b0, addr1, 64'h0, name);
    if (!abort)
      wait_resp(name);
    if (!abort)
    begin
      held = host_resp_o;
      repeat (n)
      begin
        assert (host_resp_o === held)
        else
        begin
          $display("Error: %0s held response expected %h actual %h", name, held, host_resp_o);
          err_count++;
        end
        assert (host_cmd_ready_o === 1'b0)
        else
        begin
          $display("Error: %0s cmd ready expected 0 actual %b", name, host_cmd_ready_o);
          err_count++;
        end
        step();
      end
      take_resp(resp, name);
      check_resp(name, 1'b0, addr0, exp0, resp);
    end
    if (!abort)
    begin
      take_resp(resp, name);
      check_resp(name, 1'b0, addr1, exp1, resp);
    end
    end_test(name, errs0);
  endtask

  // ----------------------------------------------------------------------
  // network model checking every packet that leaves
  // ----------------------------------------------------------------------
  always @(negedge clk_i)
  begin
    net_pkt_s     want;
    logic [255:0] want_name;
    if (rst_n_i && net_pkt_v_o === 1'b1)
    begin
      pkt_seen++;
      assert (exp_pkt_q.size() != 0)
      else
      begin
        $display("network packet %h left the bridge with none expected", net_pkt_o);
        err_count++;
      end
      if (exp_pkt_q.size() != 0)
      begin
        want      = exp_pkt_q.pop_front();
        want_name = exp_name_q.pop_front();
        assert (net_pkt_o === want)
        else
        begin
          $display("Error: %0s packet expected %h actual %h", want_name, want, net_pkt_o);
          err_count++;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial
  begin
    int           fd;
    int           rc;
    int           f_n;
    logic [255:0] kw;
    logic [255:0] name;
    logic [8*200-1:0] line_buf;
    logic         f_kind;
    logic [19:0]  f_addr;
    logic [19:0]  f_addr2;
    logic [63:0]  f_data;
    logic [63:0]  f_exp;
    logic [63:0]  f_exp2;
    logic [7:0]   f_type;
    logic [7:0]   f_reg;
    logic [31:0]  f_ret;

    rst_n_i          = 1'b0;
    host_cmd_i       = '0;
    host_cmd_v_i     = 1'b0;
    host_resp_yumi_i = 1'b0;
    net_credit_i     = 1'b0;
    net_ret_i        = '0;
    net_ret_v_i      = 1'b0;
    repeat (5) @(posedge clk_i);
    #0.5;
    rst_n_i = 1'b1;
    step();

    fd = $fopen("host_link_stim.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open host_link_stim.txt");
      err_count++;
      abort = 1;
    end

    while (!abort && $fscanf(fd, "%s", kw) == 1)
    begin
      if (kw == "#")
        rc = $fgets(line_buf, fd);
      else if (kw == "cmd")
      begin
        rc = $fscanf(fd, "%h %h %h %h %s", f_kind, f_addr, f_data, f_exp, name);
        check_line_fields(rc, 5);
        if (!abort)
          run_cmd(f_kind, f_addr, f_data, f_exp, name);
      end
      else if (kw == "credit")
      begin
        net_credit_i = 1'b1;
        step();
        net_credit_i = 1'b0;
      end
      else if (kw == "ret")
      begin
        rc = $fscanf(fd, "%h %h %h", f_type, f_reg, f_ret);
        check_line_fields(rc, 3);
        if (!abort)
        begin
          net_ret_i.pkt_type = net_ret_e'(f_type);
          net_ret_i.reg_id   = f_reg;
          net_ret_i.data     = f_ret;
          net_ret_v_i        = 1'b1;
          step();
          net_ret_v_i = 1'b0;
        end
      end
      else if (kw == "idle")
      begin
        rc = $fscanf(fd, "%d", f_n);
        check_line_fields(rc, 1);
        if (!abort)
          repeat (f_n) step();
      end
      else if (kw == "quiet")
      begin
        rc = $fscanf(fd, "%d %s", f_n, name);
        check_line_fields(rc, 2);
        if (!abort)
          quiet_window(f_n, name);
      end
      else if (kw == "drain")
      begin
        rc = $fscanf(fd, "%s", name);
        check_line_fields(rc, 1);
        if (!abort)
          drain_pkts(name);
      end
      else if (kw == "stall")
      begin
        rc = $fscanf(fd, "%d %h %h %h %h %s", f_n, f_addr, f_exp, f_addr2, f_exp2, name);
        check_line_fields(rc, 6);
        if (!abort)
          stall_test(f_n, f_addr, f_exp, f_addr2, f_exp2, name);
      end
      else
      begin
        $display("unknown stimulus keyword %0s", kw);
        err_count++;
      end
    end

    repeat (4) step();
    assert (exp_pkt_q.size() == 0)
    else
    begin
      $display("%0d expected network packets never appeared", exp_pkt_q.size());
      err_count++;
    end
    $display("tests run %0d, errors %0d", test_count, err_count);
    if (err_count == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== host_link_top.sv ====
`timescale 1ns/1ps

module host_link_top
#(
  parameter  int max_credits_p   = 4,
  parameter  int ret_fifo_els_p  = 4
)
(
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  host_link_pkg::host_msg_s                  host_cmd_i,
  input  logic                                      host_cmd_v_i,
  output logic                                      host_cmd_ready_o,
  output host_link_pkg::host_msg_s                  host_resp_o,
  output logic                                      host_resp_v_o,
  input  logic                                      host_resp_yumi_i,
  output host_link_pkg::net_pkt_s                   net_pkt_o,
  output logic                                      net_pkt_v_o,
  input  logic                                      net_credit_i,
  input  host_link_pkg::net_ret_s                   net_ret_i,
  input  logic                                      net_ret_v_i,
  input  logic [host_link_pkg::coord_width_c-1:0]   my_x_i,
  input  logic [host_link_pkg::coord_width_c-1:0]   my_y_i
);
  import host_link_pkg::*;

  localparam int credit_width_lp = $clog2(max_credits_p + 1);

  // buffered command
  host_msg_s cmd;
  logic      cmd_v;
  logic      cmd_yumi;

  // request side
  logic [dword_width_c-1:0] req_word;
  logic                     req_word_v;
  logic                     req_word_ready;
  host_req_pkt_s            req_pkt;
  logic                     req_pkt_v;
  logic                     req_pkt_yumi;

  // response side
  host_resp_pkt_s           resp_pkt;
  logic                     resp_pkt_v;
  logic                     resp_pkt_ready;
  logic [dword_width_c-1:0] resp_word;
  logic                     resp_word_v;
  logic                     resp_word_yumi;

  logic [credit_width_lp-1:0] credit_count;

  host_cmd_fifo cmd_fifo_i
  (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_i       (host_cmd_i),
    .cmd_v_i     (host_cmd_v_i),
    .cmd_ready_o (host_cmd_ready_o),
    .cmd_o       (cmd),
    .cmd_v_o     (cmd_v),
    .cmd_yumi_i  (cmd_yumi)
  );

  host_link_regs #(.max_credits_p(max_credits_p)) regs_i
  (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cmd_i            (cmd),
    .cmd_v_i          (cmd_v),
    .cmd_yumi_o       (cmd_yumi),
    .host_resp_o      (host_resp_o),
    .host_resp_v_o    (host_resp_v_o),
    .host_resp_yumi_i (host_resp_yumi_i),
    .req_word_o       (req_word),
    .req_word_v_o     (req_word_v),
    .req_word_ready_i (req_word_ready),
    .resp_word_i      (resp_word),
    .resp_word_v_i    (resp_word_v),
    .resp_word_yumi_o (resp_word_yumi),
    .credit_count_i   (credit_count)
  );

  host_req_sipo req_sipo_i
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .word_i       (req_word),
    .word_v_i     (req_word_v),
    .word_ready_o (req_word_ready),
    .pkt_o        (req_pkt),
    .pkt_v_o      (req_pkt_v),
    .pkt_yumi_i   (req_pkt_yumi)
  );

  host_resp_piso resp_piso_i
  (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .pkt_i       (resp_pkt),
    .pkt_v_i     (resp_pkt_v),
    .pkt_ready_o (resp_pkt_ready),
    .word_o      (resp_word),
    .word_v_o    (resp_word_v),
    .word_yumi_i (resp_word_yumi)
  );

  host_net_port
  #(
    .max_credits_p  (max_credits_p),
    .ret_fifo_els_p (ret_fifo_els_p)
  ) net_port_i
  (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_pkt_i        (req_pkt),
    .req_pkt_v_i      (req_pkt_v),
    .req_pkt_yumi_o   (req_pkt_yumi),
    .net_pkt_o        (net_pkt_o),
    .net_pkt_v_o      (net_pkt_v_o),
    .net_credit_i     (net_credit_i),
    .net_ret_i        (net_ret_i),
    .net_ret_v_i      (net_ret_v_i),
    .resp_pkt_o       (resp_pkt),
    .resp_pkt_v_o     (resp_pkt_v),
    .resp_pkt_ready_i (resp_pkt_ready),
    .credit_count_o   (credit_count),
    .my_x_i           (my_x_i),
    .my_y_i           (my_y_i)
  );

endmodule

// ==== host_net_port.sv ====
`timescale 1ns/1ps

module host_net_port
#(
  parameter  int max_credits_p   = 4,
  parameter  int ret_fifo_els_p  = 4,
  localparam int credit_width_lp = $clog2(max_credits_p + 1)
)
(
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  host_link_pkg::host_req_pkt_s              req_pkt_i,
  input  logic                                      req_pkt_v_i,
  output logic                                      req_pkt_yumi_o,
  output host_link_pkg::net_pkt_s                   net_pkt_o,
  output logic                                      net_pkt_v_o,
  input  logic                                      net_credit_i,
  input  host_link_pkg::net_ret_s                   net_ret_i,
  input  logic                                      net_ret_v_i,
  output host_link_pkg::host_resp_pkt_s             resp_pkt_o,
  output logic                                      resp_pkt_v_o,
  input  logic                                      resp_pkt_ready_i,
  output logic [credit_width_lp-1:0]                credit_count_o,
  input  logic [host_link_pkg::coord_width_c-1:0]   my_x_i,
  input  logic [host_link_pkg::coord_width_c-1:0]   my_y_i
);
  import host_link_pkg::*;

  localparam int ptr_width_lp   = (ret_fifo_els_p > 1) ? $clog2(ret_fifo_els_p) : 1;
  localparam int count_width_lp = $clog2(ret_fifo_els_p + 1);

  logic [credit_width_lp-1:0] credit_r;
  logic                       send;

  net_ret_s                  ret_mem_r [ret_fifo_els_p];
  logic [ptr_width_lp-1:0]   wr_ptr_r;
  logic [ptr_width_lp-1:0]   rd_ptr_r;
  logic [count_width_lp-1:0] ret_count_r;
  logic                      pop;
  net_ret_s                  ret_head;

  // ------------------------------------------------------------------
  // outgoing requests and credits
  // ------------------------------------------------------------------
  assign send           = req_pkt_v_i & (credit_r != '0);
  assign net_pkt_v_o    = send;
  assign req_pkt_yumi_o = send;
  assign credit_count_o = credit_r;

  always_comb
  begin
    net_pkt_o.addr   = req_pkt_i.addr[31:2];
    net_pkt_o.op     = req_pkt_i.op;
    net_pkt_o.reg_id = req_pkt_i.reg_id;
    // loads carry the byte offset in place of data
    if (req_pkt_i.op == e_remote_store)
      net_pkt_o.payload = req_pkt_i.data;
    else
      net_pkt_o.payload = 32'(req_pkt_i.addr[1:0]);
    net_pkt_o.y_src  = req_pkt_i.y_src;
    net_pkt_o.x_src  = req_pkt_i.x_src;
    net_pkt_o.y_dst  = req_pkt_i.y_dst;
    net_pkt_o.x_dst  = req_pkt_i.x_dst;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      credit_r <= credit_width_lp'(max_credits_p);
    else
      credit_r <= credit_r - credit_width_lp'(send) + credit_width_lp'(net_credit_i);
  end

  // ------------------------------------------------------------------
  // return queue
  // ------------------------------------------------------------------
  assign ret_head     = ret_mem_r[rd_ptr_r];
  assign resp_pkt_v_o = (ret_count_r != '0);
  assign pop          = resp_pkt_v_o & resp_pkt_ready_i;

  assign resp_pkt_o = '{reserved: '0,
                        op:       ret_head.pkt_type,
                        data:     ret_head.data,
                        load_id:  ret_head.reg_id,
                        y_dst:    my_y_i,
                        x_dst:    my_x_i};

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r    <= '0;
      rd_ptr_r    <= '0;
      ret_count_r <= '0;
    end
    else
    begin
      if (net_ret_v_i)
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(ret_fifo_els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(ret_fifo_els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      ret_count_r <= ret_count_r + count_width_lp'(net_ret_v_i) - count_width_lp'(pop);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (net_ret_v_i)
      ret_mem_r[wr_ptr_r] <= net_ret_i;
  end

  // network must not return more credits than were spent
  a_credit_max: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) credit_r <= credit_width_lp'(max_credits_p)
  );

  // returns only follow credited requests, so a full queue never sees a push
  a_ret_no_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    net_ret_v_i |-> (ret_count_r != count_width_lp'(ret_fifo_els_p)) || pop
  );

endmodule

// ==== host_link_regs.sv ====
`timescale 1ns/1ps

module host_link_regs
#(
  parameter  int max_credits_p   = 4,
  localparam int credit_width_lp = $clog2(max_credits_p + 1)
)
(
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  host_link_pkg::host_msg_s                  cmd_i,
  input  logic                                      cmd_v_i,
  output logic                                      cmd_yumi_o,
  output host_link_pkg::host_msg_s                  host_resp_o,
  output logic                                      host_resp_v_o,
  input  logic                                      host_resp_yumi_i,
  output logic [host_link_pkg::dword_width_c-1:0]   req_word_o,
  output logic                                      req_word_v_o,
  input  logic                                      req_word_ready_i,
  input  logic [host_link_pkg::dword_width_c-1:0]   resp_word_i,
  input  logic                                      resp_word_v_i,
  output logic                                      resp_word_yumi_o,
  input  logic [credit_width_lp-1:0]                credit_count_i
);
  import host_link_pkg::*;

  reg_sel_e sel;
  logic     fifo_sel;

  // ------------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------------
  always_comb
  begin
    case (cmd_i.header.addr)
      reg_req_fifo_c:     sel = e_sel_req_fifo;
      reg_credits_c:      sel = e_sel_credits;
      reg_resp_fifo_c:    sel = e_sel_resp_fifo;
      reg_resp_entries_c: sel = e_sel_resp_entries;
      default:            sel = e_sel_none;
    endcase
  end

  assign fifo_sel = (sel == e_sel_req_fifo) || (sel == e_sel_resp_fifo);

  // ------------------------------------------------------------------
  // response and handshake steering
  // ------------------------------------------------------------------
  always_comb
  begin
    host_resp_o      = '{header: cmd_i.header, data: '0};
    host_resp_v_o    = cmd_v_i;
    cmd_yumi_o       = host_resp_yumi_i;
    req_word_o       = cmd_i.data;
    req_word_v_o     = 1'b0;
    resp_word_yumi_o = 1'b0;

    case (sel)
      e_sel_req_fifo:
      begin
        // word moves into the sipo together with the yumi
        host_resp_v_o = cmd_v_i & req_word_ready_i;
        req_word_v_o  = host_resp_yumi_i;
      end
      e_sel_credits:
        host_resp_o.data = dword_width_c'(credit_count_i);
      e_sel_resp_fifo:
      begin
        host_resp_o.data = resp_word_i;
        host_resp_v_o    = cmd_v_i & resp_word_v_i;
        resp_word_yumi_o = host_resp_yumi_i;
      end
      e_sel_resp_entries:
        host_resp_o.data = dword_width_c'(resp_word_v_i);
      default:
      begin
      end
    endcase
  end

  // a pending response keeps its header until the host takes it
  a_resp_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    host_resp_v_o && !host_resp_yumi_i |=> host_resp_v_o && $stable(host_resp_o.header)
  );

  // fifo data must not slip while the host stalls
  a_fifo_data_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    host_resp_v_o && !host_resp_yumi_i && fifo_sel |=> $stable(host_resp_o.data)
  );

endmodule

// ==== host_resp_piso.sv ====
`timescale 1ns/1ps

module host_resp_piso
(
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  host_link_pkg::host_resp_pkt_s             pkt_i,
  input  logic                                      pkt_v_i,
  output logic                                      pkt_ready_o,
  output logic [host_link_pkg::dword_width_c-1:0]   word_o,
  output logic                                      word_v_o,
  input  logic                                      word_yumi_i
);
  import host_link_pkg::*;

  typedef enum logic [1:0]
  {
    e_empty,
    e_lo,
    e_hi
  } state_e;

  state_e         state_r;
  state_e         state_n;
  host_resp_pkt_s pkt_r;
  logic           load;

  assign pkt_ready_o = (state_r == e_empty);
  assign word_v_o    = (state_r != e_empty);
  assign load        = pkt_v_i & pkt_ready_o;
  assign word_o      = (state_r == e_hi) ? pkt_r[2*dword_width_c-1:dword_width_c]
                                         : pkt_r[dword_width_c-1:0];

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_empty: if (load) state_n = e_lo;
      e_lo:    if (word_yumi_i) state_n = e_hi;
      e_hi:    if (word_yumi_i) state_n = e_empty;
      default: state_n = e_empty;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      state_r <= e_empty;
    else
      state_r <= state_n;
  end

  always_ff @(posedge clk_i)
  begin
    if (load)
      pkt_r <= pkt_i;
  end

endmodule

// ==== host_req_sipo.sv ====
`timescale 1ns/1ps

module host_req_sipo
(
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic [host_link_pkg::dword_width_c-1:0]   word_i,
  input  logic                                      word_v_i,
  output logic                                      word_ready_o,
  output host_link_pkg::host_req_pkt_s              pkt_o,
  output logic                                      pkt_v_o,
  input  logic                                      pkt_yumi_i
);
  import host_link_pkg::*;

  typedef enum logic [1:0]
  {
    e_empty,
    e_half,
    e_full
  } state_e;

  state_e                     state_r;
  state_e                     state_n;
  logic [2*dword_width_c-1:0] shift_r;
  logic                       accept;

  assign word_ready_o = (state_r != e_full);
  assign pkt_v_o      = (state_r == e_full);
  assign accept       = word_v_i & word_ready_o;
  assign pkt_o        = host_req_pkt_s'(shift_r);

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_empty: if (accept) state_n = e_half;
      e_half:  if (accept) state_n = e_full;
      e_full:  if (pkt_yumi_i) state_n = e_empty;
      default: state_n = e_empty;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      state_r <= e_empty;
    else
      state_r <= state_n;
  end

  // lower word enters first and ends up in the low half
  always_ff @(posedge clk_i)
  begin
    if (accept)
      shift_r <= {word_i, shift_r[2*dword_width_c-1:dword_width_c]};
  end

endmodule

// ==== host_cmd_fifo.sv ====
`timescale 1ns/1ps

module host_cmd_fifo
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  host_link_pkg::host_msg_s cmd_i,
  input  logic                    cmd_v_i,
  output logic                    cmd_ready_o,
  output host_link_pkg::host_msg_s cmd_o,
  output logic                    cmd_v_o,
  input  logic                    cmd_yumi_i
);
  import host_link_pkg::*;

  host_msg_s  mem_r [2];
  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic       push;

  assign cmd_ready_o = (count_r != 2'd2);
  assign cmd_v_o     = (count_r != 2'd0);
  assign cmd_o       = mem_r[rd_ptr_r];
  assign push        = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= ~wr_ptr_r;
      if (cmd_yumi_i)
        rd_ptr_r <= ~rd_ptr_r;
      count_r <= count_r + 2'(push) - 2'(cmd_yumi_i);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_r[wr_ptr_r] <= cmd_i;
  end

  // register block must only take a command that is present
  a_yumi_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) cmd_yumi_i |-> cmd_v_o
  );

endmodule

// ==== host_link_pkg.sv ====
package host_link_pkg;

  // ------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------
  localparam int unsigned dword_width_c     = 64;
  localparam int unsigned host_addr_width_c = 20;
  localparam int unsigned coord_width_c     = 8;
  localparam int unsigned net_addr_width_c  = 30;

  // ------------------------------------------------------------------
  // opcodes
  // ------------------------------------------------------------------
  typedef enum logic
  {
    e_host_rd = 1'b0,
    e_host_wr = 1'b1
  } host_msg_e;

  typedef enum logic [7:0]
  {
    e_remote_load  = 8'h00,
    e_remote_store = 8'h01
  } net_op_e;

  typedef enum logic [7:0]
  {
    e_ret_load      = 8'h00,
    e_ret_store_ack = 8'h01
  } net_ret_e;

  // ------------------------------------------------------------------
  // host messages, used for commands and responses alike
  // ------------------------------------------------------------------
  typedef struct packed
  {
    host_msg_e                    msg_type;
    logic [host_addr_width_c-1:0] addr;
  } host_msg_header_s;

  typedef struct packed
  {
    host_msg_header_s         header;
    logic [dword_width_c-1:0] data;
  } host_msg_s;

  // 128-bit packets exchanged with the host as two words
  typedef struct packed
  {
    logic [15:0]              reserved;
    logic [31:0]              addr;
    net_op_e                  op;
    logic [7:0]               reg_id;
    logic [31:0]              data;
    logic [coord_width_c-1:0] y_src;
    logic [coord_width_c-1:0] x_src;
    logic [coord_width_c-1:0] y_dst;
    logic [coord_width_c-1:0] x_dst;
  } host_req_pkt_s;

  typedef struct packed
  {
    logic [63:0]              reserved;
    net_ret_e                 op;
    logic [31:0]              data;
    logic [7:0]               load_id;
    logic [coord_width_c-1:0] y_dst;
    logic [coord_width_c-1:0] x_dst;
  } host_resp_pkt_s;

  // ------------------------------------------------------------------
  // network packets
  // ------------------------------------------------------------------
  typedef struct packed
  {
    logic [net_addr_width_c-1:0] addr;
    net_op_e                     op;
    logic [7:0]                  reg_id;
    logic [31:0]                 payload;
    logic [coord_width_c-1:0]    y_src;
    logic [coord_width_c-1:0]    x_src;
    logic [coord_width_c-1:0]    y_dst;
    logic [coord_width_c-1:0]    x_dst;
  } net_pkt_s;

  typedef struct packed
  {
    net_ret_e    pkt_type;
    logic [7:0]  reg_id;
    logic [31:0] data;
  } net_ret_s;

  // ------------------------------------------------------------------
  // register map
  // ------------------------------------------------------------------
  localparam logic [host_addr_width_c-1:0] reg_req_fifo_c     = 20'h01000;
  localparam logic [host_addr_width_c-1:0] reg_credits_c      = 20'h02000;
  localparam logic [host_addr_width_c-1:0] reg_resp_fifo_c    = 20'h03000;
  localparam logic [host_addr_width_c-1:0] reg_resp_entries_c = 20'h04000;

  typedef enum logic [2:0]
  {
    e_sel_none,
    e_sel_req_fifo,
    e_sel_credits,
    e_sel_resp_fifo,
    e_sel_resp_entries
  } reg_sel_e;

endpackage
